/* hw/color_pkg.sv */
// colour definitions shared by the sprite renderers
// sprite art is stored as palette indices, PALETTE turns an index into 24-bit rgb

package color_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // ==============================
    // palette indices
    // ==============================
    // 19 distinct colours plus clear do not fit in 4 bits, so the index is 5 bits.
    // hat white shares the eye white entry, black covers both eye outlines
    typedef enum logic [4:0] {
        PAL_CLEAR         = 5'd0,   // transparent
        PAL_K_PINK        = 5'd1,
        PAL_K_PINK_DARK   = 5'd2,
        PAL_K_BLUSH       = 5'd3,
        PAL_BLACK         = 5'd4,
        PAL_WHITE         = 5'd5,   // eye white and hat trim
        PAL_EYE_BLUE      = 5'd6,
        PAL_MOUTH_RED     = 5'd7,
        PAL_MOUTH_DARK    = 5'd8,
        PAL_FEET_RED      = 5'd9,
        PAL_HAT_RED       = 5'd10,
        PAL_HAT_DARK      = 5'd11,
        PAL_D_PEACH       = 5'd12,
        PAL_D_PEACH_DARK  = 5'd13,
        PAL_D_ORANGE      = 5'd14,
        PAL_D_ORANGE_DARK = 5'd15,
        PAL_D_BLUSH       = 5'd16,
        PAL_D_FEET_YELLOW = 5'd17,
        PAL_BANDANA_BLUE  = 5'd18,
        PAL_BANDANA_DARK  = 5'd19
    } pal_idx_e;

    localparam int PAL_ENTRIES = 20;

    localparam rgb_t TRANSPARENT = '0;

    // ==============================
    // palette table, in enum order
    // ==============================
    localparam rgb_t [0:PAL_ENTRIES-1] PALETTE = '{
        '{r: 8'd0,   g: 8'd0,   b: 8'd0},     // clear
        '{r: 8'd255, g: 8'd182, b: 8'd193},   // kirby body
        '{r: 8'd230, g: 8'd140, b: 8'd160},   // kirby outline
        '{r: 8'd255, g: 8'd150, b: 8'd180},
        '{r: 8'd0,   g: 8'd0,   b: 8'd0},
        '{r: 8'd255, g: 8'd255, b: 8'd255},
        '{r: 8'd100, g: 8'd180, b: 8'd255},   // eye highlight
        '{r: 8'd200, g: 8'd50,  b: 8'd80},
        '{r: 8'd150, g: 8'd30,  b: 8'd50},
        '{r: 8'd220, g: 8'd60,  b: 8'd80},
        '{r: 8'd220, g: 8'd20,  b: 8'd60},    // santa hat
        '{r: 8'd150, g: 8'd10,  b: 8'd40},
        '{r: 8'd255, g: 8'd220, b: 8'd180},   // dee face
        '{r: 8'd230, g: 8'd180, b: 8'd140},
        '{r: 8'd255, g: 8'd150, b: 8'd100},   // dee body
        '{r: 8'd220, g: 8'd100, b: 8'd60},
        '{r: 8'd255, g: 8'd140, b: 8'd100},
        '{r: 8'd255, g: 8'd200, b: 8'd50},
        '{r: 8'd50,  g: 8'd100, b: 8'd200},   // bandana
        '{r: 8'd30,  g: 8'd70,  b: 8'd150}
    };

endpackage

/* hw/layer_mixer.sv */
// merges all renderer outputs into one pixel
// lowest slot with a hit wins; registered, one cycle

module layer_mixer (
    input  logic                 clk,
    input  logic                 rst,
    input  sprite_pkg::render_t  layers [sprite_pkg::NUM_PLAYERS],
    output color_pkg::rgb_t      color,
    output logic                 enable
);

    logic             any_hit;
    color_pkg::rgb_t  top_color;

    // ==============================
    // priority select
    // ==============================
    // walk from the highest slot down so slot 0 ends up on top
    always_comb begin
        any_hit   = 1'b0;
        top_color = color_pkg::TRANSPARENT;
        for (int i = sprite_pkg::NUM_PLAYERS - 1; i >= 0; i--) begin
            if (layers[i].hit) begin
                any_hit   = 1'b1;
                top_color = layers[i].color;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
            color  <= color_pkg::TRANSPARENT;
        end else begin
            enable <= any_hit;
            color  <= top_color;   // already transparent with no hit
        end
    end

endmodule

/* hw/player_regs.sv */
// position store for every player slot
// a write strobe replaces one slot; renderers see the new value next cycle

module player_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                pos_we,     // one-cycle write strobe
    input  sprite_pkg::slot_t   pos_slot,
    input  sprite_pkg::player_t pos_data,
    output sprite_pkg::player_t players [sprite_pkg::NUM_PLAYERS]
);

    // ==============================
    // one register per slot
    // ==============================
    for (genvar i = 0; i < sprite_pkg::NUM_PLAYERS; i++) begin : g_slot

        logic sel;

        assign sel = pos_we && (pos_slot == sprite_pkg::slot_t'(i));

        always_ff @(posedge clk) begin
            if (rst) begin
                players[i] <= sprite_pkg::PLAYER_RESET[i];
            end else if (sel) begin
                players[i] <= pos_data;   // whole record, visible included
            end
        end

    end

endmodule

/* hw/player_renderer.sv */
// renders one player: box test against the query pixel, art lookup, palette
// output is registered, one cycle after pix

module player_renderer (
    input  logic                 clk,
    input  logic                 rst,
    input  sprite_pkg::player_t  player,
    input  sprite_pkg::pixel_t   pix,
    output sprite_pkg::render_t  out
);

    localparam int EXT_W = sprite_pkg::COORD_W + 1;   // room for x + 16 at the edge

    logic [EXT_W-1:0]     x_end;
    logic [EXT_W-1:0]     y_end;
    logic                 in_box;
    sprite_pkg::local_t   row;
    sprite_pkg::local_t   col;
    color_pkg::pal_idx_e  index;
    logic                 hit_d;
    logic                 hit_q;
    color_pkg::rgb_t      color_q;

    // ==============================
    // box test
    // ==============================
    assign x_end = {1'b0, player.x} + EXT_W'(sprite_pkg::SPRITE_SIZE);
    assign y_end = {1'b0, player.y} + EXT_W'(sprite_pkg::SPRITE_SIZE);

    assign in_box = (pix.x >= player.x) && ({1'b0, pix.x} < x_end) &&
                    (pix.y >= player.y) && ({1'b0, pix.y} < y_end);

    // low bits of the offset, only meaningful inside the box
    assign col = sprite_pkg::local_t'(pix.x - player.x);
    assign row = sprite_pkg::local_t'(pix.y - player.y);

    sprite_rom rom_i (
        .sprite (player.sprite),
        .row    (row),
        .col    (col),
        .index  (index)
    );

    assign hit_d = in_box && player.visible && (index != color_pkg::PAL_CLEAR);

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit_d;
        end
    end

    always_ff @(posedge clk) begin
        color_q <= hit_d ? color_pkg::PALETTE[index] : color_pkg::TRANSPARENT;
    end

    assign out = '{hit: hit_q, color: color_q};

endmodule

/* hw/sprite_layer.sv */
// sprite layer top: position store, one renderer per player, priority mixer
// pix in at edge n gives color/enable at edge n+2, one pixel per cycle

module sprite_layer (
    input  logic                 clk,
    input  logic                 rst,
    input  sprite_pkg::pixel_t   pix,
    input  logic                 pos_we,
    input  sprite_pkg::slot_t    pos_slot,
    input  sprite_pkg::player_t  pos_data,
    output color_pkg::rgb_t      color,
    output logic                 enable
);

    sprite_pkg::player_t  players [sprite_pkg::NUM_PLAYERS];
    sprite_pkg::render_t  layers  [sprite_pkg::NUM_PLAYERS];

    player_regs regs_i (
        .clk      (clk),
        .rst      (rst),
        .pos_we   (pos_we),
        .pos_slot (pos_slot),
        .pos_data (pos_data),
        .players  (players)
    );

    // ==============================
    // one renderer per slot
    // ==============================
    for (genvar i = 0; i < sprite_pkg::NUM_PLAYERS; i++) begin : g_render
        player_renderer render_i (
            .clk    (clk),
            .rst    (rst),
            .player (players[i]),
            .pix    (pix),
            .out    (layers[i])
        );
    end

    layer_mixer mixer_i (
        .clk    (clk),
        .rst    (rst),
        .layers (layers),
        .color  (color),
        .enable (enable)
    );

endmodule

/* hw/sprite_pkg.sv */
// screen, sprite and player types for the sprite layer
// the player table comes out of reset with the placements in PLAYER_RESET

package sprite_pkg;

    localparam int COORD_W = 10;   // covers a 640x480 screen
    typedef logic [COORD_W-1:0] coord_t;

    localparam int SPRITE_SIZE = 16;
    typedef logic [$clog2(SPRITE_SIZE)-1:0] local_t;   // row or col inside a sprite

    typedef enum logic {
        SPR_KIRBY = 1'b0,
        SPR_DEE   = 1'b1
    } sprite_e;

    localparam int NUM_PLAYERS = 2;
    localparam int SLOT_W = (NUM_PLAYERS > 1) ? $clog2(NUM_PLAYERS) : 1;
    typedef logic [SLOT_W-1:0] slot_t;

    typedef struct packed {
        coord_t  x;         // top left corner
        coord_t  y;
        sprite_e sprite;
        logic    visible;
    } player_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_t;

    typedef struct packed {
        logic             hit;
        color_pkg::rgb_t  color;
    } render_t;

    // start positions
    localparam player_t [0:NUM_PLAYERS-1] PLAYER_RESET = '{
        '{x: 10'd100, y: 10'd100, sprite: SPR_KIRBY, visible: 1'b1},
        '{x: 10'd200, y: 10'd100, sprite: SPR_DEE,   visible: 1'b1}
    };

endpackage

/* hw/sprite_rom.sv */
// palette-index art of the two 16x16 side-view sprites
// pure lookup; sprite picks the art, row and col address the pixel

module sprite_rom (
    input  sprite_pkg::sprite_e  sprite,
    input  sprite_pkg::local_t   row,
    input  sprite_pkg::local_t   col,
    output color_pkg::pal_idx_e  index
);

    // ==============================
    // kirby with santa hat
    // ==============================
    function automatic color_pkg::pal_idx_e kirby_px(
        input sprite_pkg::local_t r,
        input sprite_pkg::local_t c
    );
        color_pkg::pal_idx_e px;
        px = color_pkg::PAL_CLEAR;
        case (r)
            4'd0: case (c) inside   // pompom
                [4'd7:4'd9]:  px = color_pkg::PAL_WHITE;
            endcase
            4'd1, 4'd2: case (c) inside
                4'd6, 4'd10:  px = color_pkg::PAL_HAT_DARK;
                [4'd7:4'd9]:  px = color_pkg::PAL_HAT_RED;
            endcase
            4'd3: case (c) inside   // hat brim
                [4'd5:4'd11]: px = color_pkg::PAL_WHITE;
            endcase
            4'd4, 4'd5: case (c) inside
                4'd4, 4'd11:  px = color_pkg::PAL_K_PINK_DARK;
                [4'd5:4'd10]: px = color_pkg::PAL_K_PINK;
            endcase
            4'd6: case (c) inside
                4'd3, 4'd12:               px = color_pkg::PAL_K_PINK_DARK;
                [4'd4:4'd5], [4'd8:4'd11]: px = color_pkg::PAL_K_PINK;
                [4'd6:4'd7]:               px = color_pkg::PAL_BLACK;
            endcase
            4'd7: case (c) inside   // eye row
                4'd3, 4'd12:                px = color_pkg::PAL_K_PINK_DARK;
                [4'd4:4'd5], [4'd10:4'd11]: px = color_pkg::PAL_K_PINK;
                4'd6, 4'd9:                 px = color_pkg::PAL_BLACK;
                4'd7:                       px = color_pkg::PAL_WHITE;
                4'd8:                       px = color_pkg::PAL_EYE_BLUE;
            endcase
            4'd8: case (c) inside
                4'd2, 4'd13:                     px = color_pkg::PAL_K_PINK_DARK;
                [4'd3:4'd5], [4'd8:4'd9], 4'd12: px = color_pkg::PAL_K_PINK;
                [4'd6:4'd7]:                     px = color_pkg::PAL_BLACK;
                [4'd10:4'd11]:                   px = color_pkg::PAL_K_BLUSH;
            endcase
            4'd9: case (c) inside   // smile
                4'd2, 4'd13:                px = color_pkg::PAL_K_PINK_DARK;
                [4'd3:4'd5], [4'd10:4'd12]: px = color_pkg::PAL_K_PINK;
                4'd6, 4'd9:                 px = color_pkg::PAL_MOUTH_RED;
                [4'd7:4'd8]:                px = color_pkg::PAL_MOUTH_DARK;
            endcase
            4'd10, 4'd11: case (c) inside
                4'd3, 4'd12:  px = color_pkg::PAL_K_PINK_DARK;
                [4'd4:4'd11]: px = color_pkg::PAL_K_PINK;
            endcase
            4'd12: case (c) inside
                [4'd4:4'd11]: px = color_pkg::PAL_K_PINK;
            endcase
            4'd13: case (c) inside
                [4'd5:4'd10]: px = color_pkg::PAL_K_PINK;
            endcase
            default: case (c) inside   // feet, rows 14 and 15
                [4'd5:4'd6], [4'd9:4'd10]: px = color_pkg::PAL_FEET_RED;
            endcase
        endcase
        return px;
    endfunction

    // ==============================
    // bandana dee
    // ==============================
    function automatic color_pkg::pal_idx_e dee_px(
        input sprite_pkg::local_t r,
        input sprite_pkg::local_t c
    );
        color_pkg::pal_idx_e px;
        px = color_pkg::PAL_CLEAR;
        case (r)
            4'd0: case (c) inside
                [4'd7:4'd9]:  px = color_pkg::PAL_BANDANA_BLUE;
            endcase
            4'd1: case (c) inside
                4'd6, 4'd10:  px = color_pkg::PAL_BANDANA_DARK;
                [4'd7:4'd9]:  px = color_pkg::PAL_BANDANA_BLUE;
            endcase
            4'd2: case (c) inside   // bandana meets face
                4'd5:          px = color_pkg::PAL_D_PEACH_DARK;
                [4'd6:4'd8]:   px = color_pkg::PAL_D_PEACH;
                [4'd9:4'd11]:  px = color_pkg::PAL_BANDANA_BLUE;
                4'd12:         px = color_pkg::PAL_BANDANA_DARK;
            endcase
            4'd3: case (c) inside
                4'd4:          px = color_pkg::PAL_D_PEACH_DARK;
                [4'd5:4'd9]:   px = color_pkg::PAL_D_PEACH;
                [4'd10:4'd11]: px = color_pkg::PAL_BANDANA_BLUE;
            endcase
            4'd4, 4'd5: case (c) inside
                4'd3, 4'd11:  px = color_pkg::PAL_D_PEACH_DARK;
                [4'd4:4'd10]: px = color_pkg::PAL_D_PEACH;
            endcase
            4'd6: case (c) inside
                4'd3, 4'd12:               px = color_pkg::PAL_D_PEACH_DARK;
                [4'd4:4'd5], [4'd8:4'd11]: px = color_pkg::PAL_D_PEACH;
                [4'd6:4'd7]:               px = color_pkg::PAL_BLACK;
            endcase
            4'd7: case (c) inside   // eye row
                4'd2, 4'd13:                px = color_pkg::PAL_D_PEACH_DARK;
                [4'd3:4'd5], [4'd10:4'd12]: px = color_pkg::PAL_D_PEACH;
                4'd6, 4'd9:                 px = color_pkg::PAL_BLACK;
                4'd7:                       px = color_pkg::PAL_WHITE;
                4'd8:                       px = color_pkg::PAL_EYE_BLUE;
            endcase
            4'd8: case (c) inside
                4'd2, 4'd13:                     px = color_pkg::PAL_D_ORANGE_DARK;
                [4'd3:4'd5], [4'd8:4'd9], 4'd12: px = color_pkg::PAL_D_ORANGE;
                [4'd6:4'd7]:                     px = color_pkg::PAL_BLACK;
                [4'd10:4'd11]:                   px = color_pkg::PAL_D_BLUSH;
            endcase
            4'd9, 4'd10, 4'd11: case (c) inside   // widest part of the body
                4'd1, 4'd14:  px = color_pkg::PAL_D_ORANGE_DARK;
                [4'd2:4'd13]: px = color_pkg::PAL_D_ORANGE;
            endcase
            4'd12: case (c) inside
                4'd2, 4'd13:  px = color_pkg::PAL_D_ORANGE_DARK;
                [4'd3:4'd12]: px = color_pkg::PAL_D_ORANGE;
            endcase
            4'd13: case (c) inside
                [4'd3:4'd12]: px = color_pkg::PAL_D_ORANGE;
            endcase
            default: case (c) inside   // feet
                [4'd4:4'd6], [4'd10:4'd12]: px = color_pkg::PAL_D_FEET_YELLOW;
            endcase
        endcase
        return px;
    endfunction

    assign index = (sprite == sprite_pkg::SPR_KIRBY) ? kirby_px(row, col) : dee_px(row, col);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the sprite layer testbench with Verilator, runs it and reports pass or fail.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_sprite_layer -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out="$(./obj_dir/Vtb_sprite_layer 2>&1)"
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* sim.f */
hw/color_pkg.sv
hw/sprite_pkg.sv
hw/player_regs.sv
hw/sprite_rom.sv
hw/player_renderer.sv
hw/layer_mixer.sv
hw/sprite_layer.sv
testbench/tb_sprite_layer.sv

/* testbench/tb_sprite_layer.sv */
// testbench for the sprite layer top
// drives one pixel query per cycle plus player writes, checks color/enable two cycles later

module tb_sprite_layer;

    typedef struct packed {
        sprite_pkg::sprite_e  sprite;
        sprite_pkg::local_t   row;
        sprite_pkg::local_t   col;
        logic                 opaque;
        color_pkg::rgb_t      rgb;
    } ref_px_t;

    // ==============================
    // reference pixels from the art
    // ==============================
    localparam ref_px_t REF_PX [10] = '{
        '{sprite_pkg::SPR_KIRBY, 4'd0,  4'd7,  1'b1, 24'hffffff},   // hat white
        '{sprite_pkg::SPR_KIRBY, 4'd7,  4'd8,  1'b1, 24'h64b4ff},   // eye blue
        '{sprite_pkg::SPR_DEE,   4'd0,  4'd7,  1'b1, 24'h3264c8},   // bandana blue
        '{sprite_pkg::SPR_DEE,   4'd14, 4'd4,  1'b1, 24'hffc832},   // feet yellow
        '{sprite_pkg::SPR_KIRBY, 4'd4,  4'd5,  1'b1, 24'hffb6c1},   // body pink
        '{sprite_pkg::SPR_DEE,   4'd4,  4'd5,  1'b1, 24'hffdcb4},   // face peach
        '{sprite_pkg::SPR_DEE,   4'd9,  4'd1,  1'b1, 24'hdc643c},   // dark orange
        '{sprite_pkg::SPR_KIRBY, 4'd0,  4'd0,  1'b0, 24'h000000},
        '{sprite_pkg::SPR_DEE,   4'd15, 4'd15, 1'b0, 24'h000000},
        '{sprite_pkg::SPR_KIRBY, 4'd9,  4'd1,  1'b0, 24'h000000}    // left of the smile row
    };

    localparam int K_HAT    = 0;
    localparam int K_EYE    = 1;
    localparam int D_BAND   = 2;
    localparam int D_FEET   = 3;
    localparam int K_PINK   = 4;
    localparam int D_PEACH  = 5;
    localparam int D_ORANGE = 6;
    localparam int K_CLEAR  = 7;
    localparam int D_CLEAR  = 8;
    localparam int K_GAP    = 9;

    localparam sprite_pkg::pixel_t IDLE_PIX = '{x: 10'd0, y: 10'd1023};   // never inside a box
    localparam int DRAIN_LIMIT = 10;

    logic                 clk = 1'b0;
    logic                 rst;
    sprite_pkg::pixel_t   pix;
    logic                 pos_we;
    sprite_pkg::slot_t    pos_slot;
    sprite_pkg::player_t  pos_data;
    color_pkg::rgb_t      color;
    logic                 enable;

    integer seed = 32'h1f21;

    // expected-result delay line, follows pix through the DUT
    logic                chk_in = 1'b0;
    logic                chk_q1 = 1'b0;
    logic                chk_q2 = 1'b0;
    logic                en_in, en_q1, en_q2, en_q3;
    color_pkg::rgb_t     col_in, col_q1, col_q2, col_q3;
    sprite_pkg::pixel_t  pix_q1, pix_q2, pix_q3;
    logic                en_seen;
    color_pkg::rgb_t     col_seen;
    logic [1:0]          quiet_cnt = 2'd3;
    logic                out_live = 1'b0;

    sprite_layer dut_i (
        .clk      (clk),
        .rst      (rst),
        .pix      (pix),
        .pos_we   (pos_we),
        .pos_slot (pos_slot),
        .pos_data (pos_data),
        .color    (color),
        .enable   (enable)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        chk_q1   <= chk_in;
        chk_q2   <= chk_q1;
        en_q1    <= en_in;
        en_q2    <= en_q1;
        en_q3    <= en_q2;   // q3 and the seen copies hold the checked query for the message
        col_q1   <= col_in;
        col_q2   <= col_q1;
        col_q3   <= col_q2;
        pix_q1   <= pix;
        pix_q2   <= pix_q1;
        pix_q3   <= pix_q2;
        en_seen  <= enable;
        col_seen <= color;
        if (rst) begin
            quiet_cnt <= 2'd0;
            out_live  <= 1'b1;
        end else if (quiet_cnt != 2'd3) begin
            quiet_cnt <= quiet_cnt + 2'd1;
        end
    end

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch();
        report_error($sformatf("pixel (%0d,%0d) expected en=%0b rgb=%h, got en=%0b rgb=%h",
                               pix_q3.x, pix_q3.y, en_q3, col_q3, en_seen, col_seen));
    endtask

    // ==============================
    // checks
    // ==============================
    reset_quiet: assert property (@(posedge clk) (quiet_cnt < 2'd2) |-> !enable)
        else report_error("enable high during reset or the two cycles after it");

    clear_when_off: assert property (@(posedge clk)
        (out_live && !enable) |-> (color == color_pkg::TRANSPARENT))
        else report_error("color not transparent while enable is low");

    pixel_match: assert property (@(posedge clk)
        chk_q2 |-> ((enable == en_q2) && (color == col_q2)))
        else report_mismatch();

    function automatic int pick_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic query(input int x, input int y, input logic en, input color_pkg::rgb_t c);
        @(posedge clk);
        pix    <= '{x: sprite_pkg::coord_t'(x), y: sprite_pkg::coord_t'(y)};
        pos_we <= 1'b0;
        chk_in <= 1'b1;
        en_in  <= en;
        col_in <= en ? c : color_pkg::TRANSPARENT;
    endtask

    // one reference pixel of a sprite placed at (x0, y0)
    task automatic probe(input int x0, input int y0, input int k, input logic shown);
        query(x0 + int'(REF_PX[k].col), y0 + int'(REF_PX[k].row),
              shown && REF_PX[k].opaque, REF_PX[k].rgb);
    endtask

    task automatic write_slot(input int slot, input int x, input int y,
                              input sprite_pkg::sprite_e spr, input logic vis);
        @(posedge clk);
        pos_we   <= 1'b1;
        pos_slot <= sprite_pkg::slot_t'(slot);
        pos_data <= '{x: sprite_pkg::coord_t'(x), y: sprite_pkg::coord_t'(y),
                      sprite: spr, visible: vis};
        pix      <= IDLE_PIX;
        chk_in   <= 1'b1;
        en_in    <= 1'b0;
        col_in   <= color_pkg::TRANSPARENT;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        chk_in <= 1'b0;
        pos_we <= 1'b0;
        @(negedge clk);
        while (chk_in || chk_q1 || chk_q2) begin
            if (waited == DRAIN_LIMIT) begin
                $display("timeout: the check pipeline never emptied");
                $display("sim failed");
                $fatal(1);
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin
        int kx;
        int ky;
        int dx;
        int dy;
        rst      = 1'b1;
        pix      = '{x: 10'd107, y: 10'd100};   // opaque hat pixel held through reset
        pos_we   = 1'b0;
        pos_slot = '0;
        pos_data = '0;
        en_in    = 1'b0;
        col_in   = color_pkg::TRANSPARENT;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
        end
        rst <= 1'b0;

        query(IDLE_PIX.x, IDLE_PIX.y, 1'b0, color_pkg::TRANSPARENT);
        query(50, 50, 1'b0, color_pkg::TRANSPARENT);
        probe(100, 100, K_HAT, 1'b1);
        probe(100, 100, K_EYE, 1'b1);
        probe(200, 100, D_BAND, 1'b1);
        probe(200, 100, D_FEET, 1'b1);
        probe(200, 100, D_PEACH, 1'b1);
        probe(100, 100, K_CLEAR, 1'b1);
        probe(200, 100, D_CLEAR, 1'b1);
        probe(100, 100, K_GAP, 1'b1);

        // dee on top of kirby, slot 0 wins where both are opaque
        write_slot(1, 100, 100, sprite_pkg::SPR_DEE, 1'b1);
        probe(100, 100, K_PINK, 1'b1);
        probe(100, 100, K_HAT, 1'b1);
        probe(100, 100, D_ORANGE, 1'b1);

        for (int i = 0; i < 8; i++) begin
            kx = (i == 0) ? 624 : (i == 1) ? 1015 : 1 + pick_below(300);   // edge cases first
            ky = 1 + pick_below(400);
            dx = (kx >= 320) ? 16 + pick_below(280) : 340 + pick_below(260);
            dy = 1 + pick_below(400);
            write_slot(0, kx, ky, sprite_pkg::SPR_KIRBY, 1'b1);
            write_slot(1, dx, dy, sprite_pkg::SPR_DEE, 1'b1);
            probe(kx, ky, K_HAT, 1'b1);
            query(kx - 1, ky, 1'b0, color_pkg::TRANSPARENT);
            query(kx + 5, ky - 1, 1'b0, color_pkg::TRANSPARENT);   // above a foot column
            query(0, ky, 1'b0, color_pkg::TRANSPARENT);   // wrap check
            probe(dx, dy, D_BAND, 1'b1);
        end

        write_slot(0, 100, 100, sprite_pkg::SPR_KIRBY, 1'b0);
        write_slot(1, 200, 100, sprite_pkg::SPR_DEE, 1'b1);
        probe(100, 100, K_HAT, 1'b0);
        probe(100, 100, K_PINK, 1'b0);
        probe(200, 100, D_BAND, 1'b1);
        write_slot(1, 200, 100, sprite_pkg::SPR_DEE, 1'b0);
        probe(200, 100, D_FEET, 1'b0);
        probe(200, 100, D_BAND, 1'b0);

        drain();
        $display("sim passed");
        $finish;
    end

endmodule
